//--- Makefile
# verilator build and run of the paddle chooser testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_paddle_chooser -f files.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- files.f
+incdir+.
paddle_pkg.sv
motion_detect.sv
mouse_position.sv
paddle_assigner.sv
paddle_mux.sv
paddle_chooser.sv
tb_clock.sv
tb_paddle_chooser.sv

//--- motion_detect.sv
/*
 * edge-of-travel detection for every stick axis and spinner
 * twelve channels share one registered compare
 */
`timescale 1ns/1ns
`include "paddle_defines.svh"

module motion_detect (
	input logic clk,
	input logic [`PADDLE_SLOTS-1:0][`STICK_WORD-1:0] analog,
	input logic [`PADDLE_SLOTS-1:0][`PADDLE_BYTE-1:0] paddle,
	output logic [`PADDLE_SLOTS-1:0] xs_select,
	output logic [`PADDLE_SLOTS-1:0] ys_select,
	output logic [`PADDLE_SLOTS-1:0] p_select
);
	import paddle_pkg::*;

	localparam int chans = 3 * `PADDLE_SLOTS;

	// channel order: x axes, then y axes, then spinners
	logic [chans-1:0][`PADDLE_BYTE-1:0] chan;
	logic [chans-1:0][`PADDLE_BYTE-1:0] last_chan;
	logic [chans-1:0] sel;

	always_comb begin
		for (int i = 0; i < `PADDLE_SLOTS; i++) begin
			chan[i] = stick_to_unsigned(analog[i][`PADDLE_BYTE-1:0]);
			chan[`PADDLE_SLOTS + i] =
				stick_to_unsigned(analog[i][`STICK_WORD-1:`PADDLE_BYTE]);
			chan[2 * `PADDLE_SLOTS + i] = paddle[i];
		end
	end

	// top two bits equal means the value sits in the low or high quarter
	// pulse only when the value has just changed
	always_ff @(posedge clk) begin
		for (int i = 0; i < chans; i++) begin
			last_chan[i] <= chan[i];
			sel[i] <= (chan[i] != last_chan[i]) &&
				(chan[i][`PADDLE_BYTE-1] == chan[i][`PADDLE_BYTE-2]);
		end
	end

	assign xs_select = sel[`PADDLE_SLOTS-1:0];
	assign ys_select = sel[2*`PADDLE_SLOTS-1:`PADDLE_SLOTS];
	assign p_select = sel[chans-1:2*`PADDLE_SLOTS];

endmodule

//--- mouse_position.sv
/*
 * mouse x accumulator
 * each strobe toggle adds the packet's clamped x motion,
 * saturating at the position limits
 */
`timescale 1ns/1ns
`include "paddle_defines.svh"

module mouse_position (
	input logic clk,
	input logic reset,
	input logic [`MOUSE_WORD-1:0] mouse,
	output logic [`PADDLE_BYTE-1:0] mouse_pos
);
	import paddle_pkg::*;

	localparam logic signed [8:0] clamp_hi = `MOUSE_CLAMP;
	localparam logic signed [8:0] clamp_lo = -`MOUSE_CLAMP;
	localparam logic signed [8:0] pos_hi = `POS_MAX;
	localparam logic signed [8:0] pos_lo = `POS_MIN;

	logic old_stb;
	logic signed [8:0] mx;
	logic signed [8:0] mdx;
	logic signed [8:0] mdx_clamped;
	logic signed [8:0] nmx;

	// 9-bit delta, sign bit on top of the dx byte
	assign mdx = {mouse[`MOUSE_XSIGN], mouse[`MOUSE_DX_LO+`PADDLE_BYTE-1:`MOUSE_DX_LO]};

	// overflow packets move a full clamp step in the sign's direction
	always_comb begin
		if (mouse[`MOUSE_XOVF])
			mdx_clamped = mouse[`MOUSE_XSIGN] ? clamp_lo : clamp_hi;
		else if (mdx > clamp_hi)
			mdx_clamped = clamp_hi;
		else if (mdx < clamp_lo)
			mdx_clamped = clamp_lo;
		else
			mdx_clamped = mdx;
	end

	// sum stays within -192..191, no wrap in 9 bits
	assign nmx = mx + mdx_clamped;

	always_ff @(posedge clk) begin
		if (reset) begin
			old_stb <= 1'b0;
			mx <= '0;
		end else begin
			old_stb <= mouse[`MOUSE_STB];
			if (old_stb != mouse[`MOUSE_STB]) begin
				if (nmx > pos_hi)
					mx <= pos_hi;
				else if (nmx < pos_lo)
					mx <= pos_lo;
				else
					mx <= nmx;
			end
		end
	end

	// same signed-to-unsigned mapping as the sticks
	assign mouse_pos = stick_to_unsigned(mx[`PADDLE_BYTE-1:0]);

endmodule

//--- paddle_assigner.sv
/*
 * slot assignment state
 * picks the next eligible slot, chooses one unclaimed source for it
 * and records kind, controller index, axis and alternate button flag
 */
`timescale 1ns/1ns
`include "paddle_defines.svh"

module paddle_assigner (
	input logic clk,
	input logic reset,
	input logic [`PADDLE_SLOTS-1:0] mask,
	input logic use_multi,
	input logic mouse_button,
	input logic [`PADDLE_SLOTS-1:0] xs_select,
	input logic [`PADDLE_SLOTS-1:0] ys_select,
	input logic [`PADDLE_SLOTS-1:0] p_select,
	output logic [`PADDLE_SLOTS-1:0] assigned,
	output logic [`PADDLE_SLOTS-1:0] slot_valid,
	output paddle_pkg::source_kind_t [`PADDLE_SLOTS-1:0] paddle_type,
	output logic [`PADDLE_SLOTS-1:0][1:0] slot_index,
	output logic [`PADDLE_SLOTS-1:0] slot_x_axis,
	output logic [`PADDLE_SLOTS-1:0] slot_alt,
	output logic x_claimed0,
	output logic y_claimed0
);
	import paddle_pkg::*;

	// sources already owned by a slot
	logic [`PADDLE_SLOTS-1:0] xs_claimed;
	logic [`PADDLE_SLOTS-1:0] ys_claimed;
	logic [`PADDLE_SLOTS-1:0] p_claimed;
	logic mouse_claimed;

	logic [`PADDLE_SLOTS-1:0] prev_done;
	logic [`PADDLE_SLOTS-1:0] eligible;
	logic found;
	logic [1:0] target;
	logic hit;
	source_kind_t pick_type;
	logic [1:0] pick_idx;
	logic pick_x_axis;
	logic pick_y_axis;

	// a slot waits for the previous enabled slot
	always_comb begin
		prev_done[0] = 1'b1;
		for (int y = 1; y < `PADDLE_SLOTS; y++)
			prev_done[y] = ~mask[y-1] | slot_valid[y-1];
		eligible = ~slot_valid & mask & prev_done;
	end

	// only the lowest eligible slot is looked at
	always_comb begin
		found = 1'b0;
		target = '0;
		for (int y = 0; y < `PADDLE_SLOTS; y++) begin
			if (eligible[y] && !found) begin
				found = 1'b1;
				target = 2'(y);
			end
		end
	end

	// later kinds override earlier ones, higher index wins within a kind
	always_comb begin
		hit = 1'b0;
		pick_type = src_spinner;
		pick_idx = '0;
		pick_x_axis = 1'b0;
		pick_y_axis = 1'b0;
		for (int i = 0; i < `PADDLE_SLOTS; i++) begin
			if (xs_select[i] && !xs_claimed[i]) begin
				hit = 1'b1;
				pick_type = src_analog;
				pick_idx = 2'(i);
				pick_x_axis = 1'b1;
				pick_y_axis = 1'b0;
			end
		end
		for (int i = 0; i < `PADDLE_SLOTS; i++) begin
			if (ys_select[i] && !ys_claimed[i]) begin
				hit = 1'b1;
				pick_type = src_analog;
				pick_idx = 2'(i);
				pick_x_axis = 1'b0;
				pick_y_axis = 1'b1;
			end
		end
		for (int i = 0; i < `PADDLE_SLOTS; i++) begin
			if (p_select[i] && !p_claimed[i]) begin
				hit = 1'b1;
				pick_type = src_spinner;
				pick_idx = 2'(i);
				pick_x_axis = 1'b0;
				pick_y_axis = 1'b0;
			end
		end
		// mouse is always reported as controller 0
		if (mouse_button && !mouse_claimed) begin
			hit = 1'b1;
			pick_type = src_mouse;
			pick_idx = '0;
			pick_x_axis = 1'b0;
			pick_y_axis = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			assigned <= '0;
			slot_valid <= '0;
			slot_index <= '0;
			slot_x_axis <= '0;
			slot_alt <= '0;
			xs_claimed <= '0;
			ys_claimed <= '0;
			p_claimed <= '0;
			mouse_claimed <= 1'b0;
			for (int y = 0; y < `PADDLE_SLOTS; y++)
				paddle_type[y] <= src_spinner;
		end else begin
			assigned <= '0;
			if (found && hit) begin
				assigned[target] <= 1'b1;
				slot_valid[target] <= 1'b1;
				paddle_type[target] <= pick_type;
				slot_index[target] <= pick_idx;
				slot_x_axis[target] <= pick_x_axis;
				// shared y axes use the alternate button
				slot_alt[target] <= pick_y_axis & use_multi;
				// without use_multi a stick gives up both axes at once
				if (pick_x_axis) begin
					xs_claimed[pick_idx] <= 1'b1;
					if (!use_multi)
						ys_claimed[pick_idx] <= 1'b1;
				end
				if (pick_y_axis) begin
					ys_claimed[pick_idx] <= 1'b1;
					if (!use_multi)
						xs_claimed[pick_idx] <= 1'b1;
				end
				if (pick_type == src_spinner)
					p_claimed[pick_idx] <= 1'b1;
				if (pick_type == src_mouse)
					mouse_claimed <= 1'b1;
			end
		end
	end

	// the mouse button rule looks at stick 0
	assign x_claimed0 = xs_claimed[0];
	assign y_claimed0 = ys_claimed[0];

endmodule

//--- paddle_chooser.sv
/*
 * paddle chooser top level
 * motion detection, mouse accumulator, slot assigner and output mux
 */
`timescale 1ns/1ns
`include "paddle_defines.svh"

module paddle_chooser (
	input logic clk,
	input logic reset,
	input logic [`PADDLE_SLOTS-1:0] mask,
	input logic use_multi,
	input logic [`MOUSE_WORD-1:0] mouse,
	input logic [`PADDLE_SLOTS-1:0][`STICK_WORD-1:0] analog,
	input logic [`PADDLE_SLOTS-1:0][`PADDLE_BYTE-1:0] paddle,
	input logic [`PADDLE_SLOTS-1:0] buttons_in,
	input logic [`PADDLE_SLOTS-1:0] alt_b_in,
	output logic [`PADDLE_SLOTS-1:0] assigned,
	output logic [`PADDLE_SLOTS-1:0][`PADDLE_BYTE-1:0] pd_out,
	output paddle_pkg::source_kind_t [`PADDLE_SLOTS-1:0] paddle_type,
	output logic [`PADDLE_SLOTS-1:0] paddle_but
);

	// one-cycle extreme pulses per source
	logic [`PADDLE_SLOTS-1:0] xs_select;
	logic [`PADDLE_SLOTS-1:0] ys_select;
	logic [`PADDLE_SLOTS-1:0] p_select;

	logic [`PADDLE_BYTE-1:0] mouse_pos;
	wire mouse_button = mouse[`MOUSE_BTN];

	// slot state from the assigner
	logic [`PADDLE_SLOTS-1:0] slot_valid;
	logic [`PADDLE_SLOTS-1:0][1:0] slot_index;
	logic [`PADDLE_SLOTS-1:0] slot_x_axis;
	logic [`PADDLE_SLOTS-1:0] slot_alt;
	logic x_claimed0;
	logic y_claimed0;

	motion_detect u_motion (
		.clk(clk),
		.analog(analog),
		.paddle(paddle),
		.xs_select(xs_select),
		.ys_select(ys_select),
		.p_select(p_select)
	);

	mouse_position u_mouse (
		.clk(clk),
		.reset(reset),
		.mouse(mouse),
		.mouse_pos(mouse_pos)
	);

	paddle_assigner u_assign (
		.clk(clk),
		.reset(reset),
		.mask(mask),
		.use_multi(use_multi),
		.mouse_button(mouse_button),
		.xs_select(xs_select),
		.ys_select(ys_select),
		.p_select(p_select),
		.assigned(assigned),
		.slot_valid(slot_valid),
		.paddle_type(paddle_type),
		.slot_index(slot_index),
		.slot_x_axis(slot_x_axis),
		.slot_alt(slot_alt),
		.x_claimed0(x_claimed0),
		.y_claimed0(y_claimed0)
	);

	paddle_mux u_mux (
		.analog(analog),
		.paddle(paddle),
		.buttons_in(buttons_in),
		.alt_b_in(alt_b_in),
		.mouse_button(mouse_button),
		.mouse_pos(mouse_pos),
		.slot_valid(slot_valid),
		.paddle_type(paddle_type),
		.slot_index(slot_index),
		.slot_x_axis(slot_x_axis),
		.slot_alt(slot_alt),
		.x_claimed0(x_claimed0),
		.y_claimed0(y_claimed0),
		.pd_out(pd_out),
		.paddle_but(paddle_but)
	);

endmodule

//--- paddle_defines.svh
/*
 * shared constants for the paddle chooser
 * slot and byte widths, stick word layout, mouse packet fields,
 * per-packet motion clamp and mouse position limits
 */
`ifndef PADDLE_DEFINES_SVH
`define PADDLE_DEFINES_SVH

// output slots, also the count of each source kind
`define PADDLE_SLOTS 4
// position byte
`define PADDLE_BYTE 8
// one analog stick, x in the low byte and y in the high byte
`define STICK_WORD 16

// ps/2 mouse packet as delivered by the host side
`define MOUSE_WORD 25
`define MOUSE_BTN 0
`define MOUSE_XSIGN 4
`define MOUSE_XOVF 6
`define MOUSE_DX_LO 8
`define MOUSE_STB 24

// largest x step taken from a single packet
`define MOUSE_CLAMP 64
// signed range of the accumulated mouse position
`define POS_MIN (-128)
`define POS_MAX 127

`endif

//--- paddle_mux.sv
/*
 * per-slot output selection
 * position byte and button come straight from the owning source
 */
`timescale 1ns/1ns
`include "paddle_defines.svh"

module paddle_mux (
	input logic [`PADDLE_SLOTS-1:0][`STICK_WORD-1:0] analog,
	input logic [`PADDLE_SLOTS-1:0][`PADDLE_BYTE-1:0] paddle,
	input logic [`PADDLE_SLOTS-1:0] buttons_in,
	input logic [`PADDLE_SLOTS-1:0] alt_b_in,
	input logic mouse_button,
	input logic [`PADDLE_BYTE-1:0] mouse_pos,
	input logic [`PADDLE_SLOTS-1:0] slot_valid,
	input paddle_pkg::source_kind_t [`PADDLE_SLOTS-1:0] paddle_type,
	input logic [`PADDLE_SLOTS-1:0][1:0] slot_index,
	input logic [`PADDLE_SLOTS-1:0] slot_x_axis,
	input logic [`PADDLE_SLOTS-1:0] slot_alt,
	input logic x_claimed0,
	input logic y_claimed0,
	output logic [`PADDLE_SLOTS-1:0][`PADDLE_BYTE-1:0] pd_out,
	output logic [`PADDLE_SLOTS-1:0] paddle_but
);
	import paddle_pkg::*;

	// raw axis byte of the stick each slot points at
	logic [`PADDLE_SLOTS-1:0][`PADDLE_BYTE-1:0] axis_byte;

	always_comb begin
		for (int s = 0; s < `PADDLE_SLOTS; s++) begin
			if (slot_x_axis[s])
				axis_byte[s] = analog[slot_index[s]][`PADDLE_BYTE-1:0];
			else
				axis_byte[s] = analog[slot_index[s]][`STICK_WORD-1:`PADDLE_BYTE];
		end
	end

	// positions are inverted on the way out
	always_comb begin
		for (int s = 0; s < `PADDLE_SLOTS; s++) begin
			pd_out[s] = '0;
			paddle_but[s] = 1'b0;
			if (slot_valid[s]) begin
				case (paddle_type[s])
					src_spinner: begin
						pd_out[s] = ~paddle[slot_index[s]];
						paddle_but[s] = buttons_in[slot_index[s]];
					end
					src_analog: begin
						pd_out[s] = ~stick_to_unsigned(axis_byte[s]);
						paddle_but[s] = slot_alt[s] ? alt_b_in[slot_index[s]]
							: buttons_in[slot_index[s]];
					end
					src_mouse: begin
						pd_out[s] = ~mouse_pos;
						// stick 0 button doubles as a mouse button while stick 0 is free
						paddle_but[s] = mouse_button |
							(~x_claimed0 & ~y_claimed0 & buttons_in[0]);
					end
					default: begin
						pd_out[s] = '0;
						paddle_but[s] = 1'b0;
					end
				endcase
			end
		end
	end

endmodule

//--- paddle_pkg.sv
/*
 * paddle chooser types and helpers
 * source_kind_t names what drives a filled slot
 * stick_to_unsigned maps a signed stick byte onto 0..255
 */
`include "paddle_defines.svh"

package paddle_pkg;

	// kind of source that owns a slot
	// spinner is the reset value, so an empty slot reads as 0
	typedef enum logic [1:0] {
		src_spinner = 2'd0,
		src_analog = 2'd1,
		src_mouse = 2'd2
	} source_kind_t;

	// signed -128..127 becomes unsigned 0..255
	// centre of travel lands on 8'h80
	function automatic logic [`PADDLE_BYTE-1:0] stick_to_unsigned(
		input logic [`PADDLE_BYTE-1:0] value
	);
		logic [`PADDLE_BYTE-1:0] result;
		result = value;
		result[`PADDLE_BYTE-1] = ~value[`PADDLE_BYTE-1];
		return result;
	endfunction

endpackage

//--- tb_clock.sv
/*
 * testbench clock and reset generator
 * 4 ns clock, reset high for 3 cycles at start and after each restart request
 */
`timescale 1ns/1ns

module tb_clock (
	input logic restart,
	output logic clk,
	output logic reset
);
	// reset edges still to come after the current one
	int hold;

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		hold = 2;
	end

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (restart) begin
			reset <= 1'b1;
			hold <= 2;
		end else if (hold != 0) begin
			reset <= 1'b1;
			hold <= hold - 1;
		end else begin
			reset <= 1'b0;
		end
	end

endmodule

//--- tb_paddle_chooser.sv
/*
 * paddle chooser testbench
 * random stick, spinner and mouse stimulus over several reset phases
 * cycle model of slot claiming, mouse accumulation and output selection
 */
`timescale 1ns/1ns
`include "paddle_defines.svh"

module tb_paddle_chooser;
	import paddle_pkg::*;

	localparam int slots = `PADDLE_SLOTS;
	localparam int chans = 3 * `PADDLE_SLOTS;
	localparam int phases = 8;
	localparam int phase_cycles = 300;
	localparam int fill_timeout = 4000;
	localparam int reset_timeout = 8;

	// source kinds as the model sees them
	localparam int k_none = 0;
	localparam int k_x = 1;
	localparam int k_y = 2;
	localparam int k_spin = 3;
	localparam int k_mouse = 4;

	logic clk;
	logic reset;
	logic restart;
	logic restart_pending;

	// dut inputs
	logic [slots-1:0] mask;
	logic use_multi;
	logic [`MOUSE_WORD-1:0] mouse;
	logic [slots-1:0][`STICK_WORD-1:0] analog;
	logic [slots-1:0][`PADDLE_BYTE-1:0] paddle;
	logic [slots-1:0] buttons_in;
	logic [slots-1:0] alt_b_in;

	// dut outputs
	logic [slots-1:0] assigned;
	logic [slots-1:0][`PADDLE_BYTE-1:0] pd_out;
	source_kind_t [slots-1:0] paddle_type;
	logic [slots-1:0] paddle_but;

	// reference model state
	logic [`PADDLE_BYTE-1:0] m_last [chans];
	logic [chans-1:0] m_sel;
	int m_pos;
	logic m_old_stb;
	logic [slots-1:0] m_assigned;
	logic [slots-1:0] m_valid;
	logic [slots-1:0] m_xaxis;
	logic [slots-1:0] m_alt;
	logic [slots-1:0] m_xc;
	logic [slots-1:0] m_yc;
	logic [slots-1:0] m_pc;
	logic m_mc;
	source_kind_t m_type [slots];
	int m_idx [slots];

	// slots seen filled through assigned pulses in this phase
	logic [slots-1:0] filled_seen;
	int fills_seen;

	tb_clock clock_gen (
		.restart(restart),
		.clk(clk),
		.reset(reset)
	);

	paddle_chooser dut (
		.clk(clk),
		.reset(reset),
		.mask(mask),
		.use_multi(use_multi),
		.mouse(mouse),
		.analog(analog),
		.paddle(paddle),
		.buttons_in(buttons_in),
		.alt_b_in(alt_b_in),
		.assigned(assigned),
		.pd_out(pd_out),
		.paddle_type(paddle_type),
		.paddle_but(paddle_but)
	);

	// unsigned view of one channel
	// channels run x axes first, then y axes, then spinners
	// flipping the top bit centres a signed stick byte on 8'h80
	function automatic logic [`PADDLE_BYTE-1:0] chan_byte(input int i);
		if (i < slots)
			return analog[i][`PADDLE_BYTE-1:0] ^ 8'h80;
		else if (i < 2 * slots)
			return analog[i-slots][`STICK_WORD-1:`PADDLE_BYTE] ^ 8'h80;
		else
			return paddle[i-2*slots];
	endfunction

	// x step of one packet after overflow handling and clamping
	function automatic int mouse_delta(input logic [`MOUSE_WORD-1:0] pkt);
		int d;
		d = int'(pkt[`MOUSE_DX_LO +: `PADDLE_BYTE]);
		if (pkt[`MOUSE_XSIGN])
			d = d - 256;
		if (pkt[`MOUSE_XOVF])
			d = pkt[`MOUSE_XSIGN] ? -`MOUSE_CLAMP : `MOUSE_CLAMP;
		else if (d > `MOUSE_CLAMP)
			d = `MOUSE_CLAMP;
		else if (d < -`MOUSE_CLAMP)
			d = -`MOUSE_CLAMP;
		return d;
	endfunction

	// mostly values in the outer quarters of travel
	function automatic logic [`PADDLE_BYTE-1:0] pick_value();
		logic [`PADDLE_BYTE-1:0] v;
		v = 8'($urandom);
		if ($urandom_range(9) < 7)
			v[6] = v[7];
		return v;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_bits(input string name, input logic [slots-1:0] got,
		input logic [slots-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] time %0t %s: got %b expected %b", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "vector mismatch");
		end
	endtask

	task automatic check_kind(input string name, input source_kind_t got,
		input source_kind_t exp);
		if (got !== exp) begin
			$display("[ERROR] time %0t %s: got %0d expected %0d", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "kind mismatch");
		end
	endtask

	task automatic check_byte(input string name, input logic [`PADDLE_BYTE-1:0] got,
		input logic [`PADDLE_BYTE-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] time %0t %s: got %h expected %h", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "byte mismatch");
		end
	endtask

	// register update of the model
	// inputs still hold their pre-edge values
	task automatic model_edge();
		logic [chans-1:0] next_sel;
		logic [`PADDLE_BYTE-1:0] b;
		int tgt;
		int kind;
		int idx;
		int p;
		// extreme detection has no reset
		for (int i = 0; i < chans; i++) begin
			b = chan_byte(i);
			next_sel[i] = (b != m_last[i]) && (b[7] == b[6]);
			m_last[i] = b;
		end
		if (reset) begin
			m_pos = 0;
			m_old_stb = 1'b0;
			m_assigned = '0;
			m_valid = '0;
			m_xaxis = '0;
			m_alt = '0;
			m_xc = '0;
			m_yc = '0;
			m_pc = '0;
			m_mc = 1'b0;
			for (int s = 0; s < slots; s++) begin
				m_type[s] = src_spinner;
				m_idx[s] = 0;
			end
		end else begin
			// saturating mouse accumulator on a strobe toggle
			if (mouse[`MOUSE_STB] != m_old_stb) begin
				p = m_pos + mouse_delta(mouse);
				if (p > `POS_MAX)
					p = `POS_MAX;
				if (p < `POS_MIN)
					p = `POS_MIN;
				m_pos = p;
			end
			m_old_stb = mouse[`MOUSE_STB];
			// lowest unfilled enabled slot whose predecessor is done
			tgt = -1;
			for (int y = 0; y < slots; y++) begin
				if (tgt < 0 && !m_valid[y] && mask[y] &&
					(y == 0 || !mask[y-1] || m_valid[y-1]))
					tgt = y;
			end
			// later kinds and higher controllers take precedence
			kind = k_none;
			idx = 0;
			for (int i = 0; i < slots; i++) begin
				if (m_sel[i] && !m_xc[i]) begin
					kind = k_x;
					idx = i;
				end
			end
			for (int i = 0; i < slots; i++) begin
				if (m_sel[slots+i] && !m_yc[i]) begin
					kind = k_y;
					idx = i;
				end
			end
			for (int i = 0; i < slots; i++) begin
				if (m_sel[2*slots+i] && !m_pc[i]) begin
					kind = k_spin;
					idx = i;
				end
			end
			if (mouse[`MOUSE_BTN] && !m_mc) begin
				kind = k_mouse;
				idx = 0;
			end
			m_assigned = '0;
			if (tgt >= 0 && kind != k_none) begin
				m_assigned[tgt] = 1'b1;
				m_valid[tgt] = 1'b1;
				m_idx[tgt] = idx;
				m_xaxis[tgt] = (kind == k_x);
				m_alt[tgt] = (kind == k_y) && use_multi;
				if (kind == k_x || kind == k_y) begin
					m_type[tgt] = src_analog;
					// one stick axis drags the other along unless sharing
					if (kind == k_x || !use_multi)
						m_xc[idx] = 1'b1;
					if (kind == k_y || !use_multi)
						m_yc[idx] = 1'b1;
				end else if (kind == k_spin) begin
					m_type[tgt] = src_spinner;
					m_pc[idx] = 1'b1;
				end else begin
					m_type[tgt] = src_mouse;
					m_mc = 1'b1;
				end
			end
		end
		m_sel = next_sel;
	endtask

	task automatic drive_stimulus();
		int r;
		int ch;
		restart <= restart_pending;
		if (restart_pending) begin
			mask <= 4'($urandom);
			use_multi <= 1'($urandom);
		end
		restart_pending = 1'b0;
		r = int'($urandom_range(99));
		ch = int'($urandom_range(slots - 1));
		// one source moves now and then
		// raw stick bytes are signed
		if (r < 5)
			analog[ch][`PADDLE_BYTE-1:0] <= pick_value() ^ 8'h80;
		else if (r < 10)
			analog[ch][`STICK_WORD-1:`PADDLE_BYTE] <= pick_value() ^ 8'h80;
		else if (r < 15)
			paddle[ch] <= pick_value();
		else if (r < 22) begin
			mouse[`MOUSE_STB] <= ~mouse[`MOUSE_STB];
			mouse[`MOUSE_DX_LO +: `PADDLE_BYTE] <= 8'($urandom);
			mouse[`MOUSE_XSIGN] <= 1'($urandom);
			mouse[`MOUSE_XOVF] <= ($urandom_range(9) == 0);
			// y motion byte is ignored by the dut
			mouse[`MOUSE_DX_LO+`PADDLE_BYTE +: `PADDLE_BYTE] <= 8'($urandom);
		end
		// rare mouse presses are released a few cycles later
		if (!mouse[`MOUSE_BTN] && $urandom_range(199) == 0)
			mouse[`MOUSE_BTN] <= 1'b1;
		else if (mouse[`MOUSE_BTN] && $urandom_range(3) == 0)
			mouse[`MOUSE_BTN] <= 1'b0;
		if ($urandom_range(7) == 0)
			buttons_in <= 4'($urandom);
		if ($urandom_range(7) == 0)
			alt_b_in <= 4'($urandom);
	endtask

	// expected outputs come from model state and the new inputs
	task automatic check_outputs();
		logic [slots-1:0] exp_but;
		logic [`PADDLE_BYTE-1:0] exp_pd;
		logic [`PADDLE_BYTE-1:0] ab;
		int idx;
		check_bits("assigned", assigned, m_assigned);
		for (int s = 0; s < slots; s++) begin
			idx = m_idx[s];
			exp_pd = '0;
			exp_but[s] = 1'b0;
			if (m_valid[s]) begin
				if (m_type[s] == src_spinner) begin
					exp_pd = ~paddle[idx];
					exp_but[s] = buttons_in[idx];
				end else if (m_type[s] == src_analog) begin
					ab = m_xaxis[s] ? analog[idx][`PADDLE_BYTE-1:0]
						: analog[idx][`STICK_WORD-1:`PADDLE_BYTE];
					exp_pd = ~(ab ^ 8'h80);
					exp_but[s] = m_alt[s] ? alt_b_in[idx] : buttons_in[idx];
				end else begin
					exp_pd = ~(8'(m_pos) ^ 8'h80);
					exp_but[s] = mouse[`MOUSE_BTN] | (~m_xc[0] & ~m_yc[0] & buttons_in[0]);
				end
			end
			check_kind($sformatf("paddle_type[%0d]", s), paddle_type[s], m_type[s]);
			check_byte($sformatf("pd_out[%0d]", s), pd_out[s], exp_pd);
		end
		check_bits("paddle_but", paddle_but, exp_but);
		filled_seen |= assigned;
		fills_seen += $countones(assigned);
	endtask

	task automatic step_cycle();
		@(posedge clk);
		model_edge();
		drive_stimulus();
		@(negedge clk);
		check_outputs();
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		step_cycle();
		// a restart request reaches the reset line one edge later
		while (!reset) begin
			if (n == reset_timeout)
				abort_run("reset was not asserted after a restart request");
			step_cycle();
			n++;
		end
		n = 0;
		while (reset) begin
			if (n == reset_timeout)
				abort_run("reset was not released in time");
			step_cycle();
			n++;
		end
		filled_seen = '0;
	endtask

	task automatic wait_slots_filled();
		int n;
		n = 0;
		while ((filled_seen & mask) != mask) begin
			if (n == fill_timeout)
				abort_run("enabled slots were not all filled before the timeout");
			step_cycle();
			n++;
		end
	endtask

	initial begin
		void'($urandom(32'hbb0f));
		fills_seen = 0;
		filled_seen = '0;
		restart = 1'b0;
		restart_pending = 1'b0;
		mask = 4'($urandom);
		use_multi = 1'($urandom);
		// sticks and spinners start at centre travel
		analog = '0;
		paddle = {slots{8'h80}};
		mouse = '0;
		buttons_in = '0;
		alt_b_in = '0;
		for (int i = 0; i < chans; i++)
			m_last[i] = chan_byte(i);
		m_sel = '0;
		m_pos = 0;
		m_old_stb = 1'b0;
		for (int ph = 0; ph < phases; ph++) begin
			if (ph > 0)
				restart_pending = 1'b1;
			wait_reset_release();
			for (int c = 0; c < phase_cycles; c++)
				step_cycle();
			wait_slots_filled();
		end
		if (fills_seen > 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("no slot was filled during the whole run");
			$display("Simulation FAILED");
			$fatal(1, "run stopped");
		end
	end

endmodule
